// ==== tests/glb_core_input.txt ====
# W addr data | R addr expected | S start count then data | L start count then expected
# All fields hex, comment lines start with a lone hash
W 005 1234
W 2f0 beef
R 005 1234
R 2f0 beef
W 0a8 dead
S 0a0 8
1111 2222 3333 4444 5555 6666 7777 8888
R 0a0 1111
R 0a1 2222
R 0a2 3333
R 0a3 4444
R 0a4 5555
R 0a5 6666
R 0a6 7777
R 0a7 8888
R 0a8 dead
W 1fe c001
W 1ff c002
W 200 c003
W 201 c004
L 1fe 4
c001 c002 c003 c004
W 003 feed
S 3fd 6
a001 a002 a003 a004 a005 a006
L 3fd 6
a001 a002 a003 a004 a005 a006
R 003 feed

// ==== filelist.f ====
+incdir+src
src/glb_pkg.sv
src/glb_bank.sv
src/glb_core_switch.sv
src/glb_core_store_dma.sv
src/glb_core_load_dma.sv
src/glb_core.sv
tests/tb_glb_core.sv

// ==== Makefile ====
# Verilator flow for the global buffer tile testbench, run from the project root
VERILATOR ?= verilator
TOP       ?= tb_glb_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_glb_core.sv ====
/* Runs the records of tests/glb_core_input.txt from the project root. S and L records hold
   at most MAX_WORDS words, and no processor access overlaps a running DMA */
`timescale 1ns/1ps
`include "glb_defines.svh"

module tb_glb_core;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int IDLE_CYCLES    = 8;
    localparam int MAX_WORDS      = 64;

    logic                  clk;
    logic                  rst_n;

    // Processor port
    glb_pkg::wr_packet_t   proc_wr_packet;
    glb_pkg::rdrq_packet_t proc_rdrq_packet;
    glb_pkg::rdrs_packet_t proc_rdrs_packet;

    // Fabric stream
    glb_pkg::glb_data_t    stream_data_f2g;
    logic                  stream_data_valid_f2g;
    glb_pkg::glb_data_t    stream_data_g2f;
    logic                  stream_data_valid_g2f;

    // Headers, starts, interrupts
    glb_pkg::dma_header_t  cfg_st_dma_header;
    glb_pkg::dma_header_t  cfg_ld_dma_header;
    logic                  strm_f2g_start_pulse;
    logic                  strm_g2f_start_pulse;
    logic [1:0]            interrupt_pulse;

    int                    errors = 0;
    logic                  aborted = 1'b0;

    // Interrupt pulses seen so far
    int                    st_irq_count = 0;
    int                    ld_irq_count = 0;

    // Data words of the current DMA record
    glb_pkg::glb_data_t    word_q [$];

    glb_core i_glb_core (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .proc_wr_packet        (proc_wr_packet),
        .proc_rdrq_packet      (proc_rdrq_packet),
        .proc_rdrs_packet      (proc_rdrs_packet),
        .stream_data_f2g       (stream_data_f2g),
        .stream_data_valid_f2g (stream_data_valid_f2g),
        .stream_data_g2f       (stream_data_g2f),
        .stream_data_valid_g2f (stream_data_valid_g2f),
        .cfg_st_dma_header     (cfg_st_dma_header),
        .cfg_ld_dma_header     (cfg_ld_dma_header),
        .strm_f2g_start_pulse  (strm_f2g_start_pulse),
        .strm_g2f_start_pulse  (strm_g2f_start_pulse),
        .interrupt_pulse       (interrupt_pulse)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // Count every interrupt cycle
    always @(posedge clk) begin
        if (interrupt_pulse[0]) begin
            st_irq_count <= st_irq_count + 1;
        end
        if (interrupt_pulse[1]) begin
            ld_irq_count <= ld_irq_count + 1;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    // Stops the remaining records
    task automatic report_abort(input string what);
        report_problem(what);
        aborted = 1'b1;
    endtask

    task automatic check_idle_outputs();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (stream_data_valid_g2f !== 1'b0) begin
                report_mismatch("stream_data_valid_g2f", 32'd0, 32'(stream_data_valid_g2f));
            end
            if (proc_rdrs_packet.rd_data_valid !== 1'b0) begin
                report_mismatch("proc_rdrs_packet.rd_data_valid", 32'd0,
                                32'(proc_rdrs_packet.rd_data_valid));
            end
            if (interrupt_pulse !== 2'b00) begin
                report_mismatch("interrupt_pulse", 32'd0, 32'(interrupt_pulse));
            end
        end
    endtask

    task automatic proc_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        proc_wr_packet.wr_en   = 1'b1;
        proc_wr_packet.wr_addr = glb_pkg::glb_addr_t'(addr);
        proc_wr_packet.wr_data = glb_pkg::glb_data_t'(data);
        @(negedge clk);
        proc_wr_packet.wr_en   = 1'b0;
    endtask

    // Response due 3 cycles after the request and valid for one cycle
    task automatic proc_read_check(input logic [31:0] addr, input logic [31:0] expected);
        int   lat;
        logic seen;
        @(negedge clk);
        proc_rdrq_packet.rd_en   = 1'b1;
        proc_rdrq_packet.rd_addr = glb_pkg::glb_addr_t'(addr);
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < TIMEOUT_CYCLES) begin
            @(negedge clk);
            proc_rdrq_packet.rd_en = 1'b0;
            lat++;
            seen = proc_rdrs_packet.rd_data_valid;
        end
        if (!seen) begin
            report_abort($sformatf("no read response for address 0x%h",
                                   glb_pkg::glb_addr_t'(addr)));
        end else begin
            if (lat != 3) begin
                report_mismatch("read latency in cycles", 32'd3, 32'(lat));
            end
            if (proc_rdrs_packet.rd_data !== glb_pkg::glb_data_t'(expected)) begin
                report_mismatch($sformatf("proc_rdrs_packet.rd_data @0x%h",
                                          glb_pkg::glb_addr_t'(addr)),
                                expected, 32'(proc_rdrs_packet.rd_data));
            end
            @(negedge clk);
            if (proc_rdrs_packet.rd_data_valid !== 1'b0) begin
                report_mismatch("proc_rdrs_packet.rd_data_valid", 32'd0,
                                32'(proc_rdrs_packet.rd_data_valid));
            end
        end
    endtask

    task automatic store_dma_run(input logic [31:0] start, input int nw);
        int base;
        int t;
        base = st_irq_count;
        @(negedge clk);
        cfg_st_dma_header.start_addr = glb_pkg::glb_addr_t'(start);
        cfg_st_dma_header.num_words  = glb_pkg::num_words_t'(nw);
        strm_f2g_start_pulse         = 1'b1;
        @(negedge clk);
        strm_f2g_start_pulse = 1'b0;
        for (int i = 0; i < nw; i++) begin
            // Idle beat with junk data before every third word
            if (i % 3 == 1) begin
                stream_data_valid_f2g = 1'b0;
                stream_data_f2g       = ~word_q[i];
                @(negedge clk);
            end
            // Restart mid-job with another header that must be ignored
            if (i == nw / 2) begin
                cfg_st_dma_header.start_addr = glb_pkg::glb_addr_t'(start ^ 32'h100);
                cfg_st_dma_header.num_words  = glb_pkg::num_words_t'(2);
                strm_f2g_start_pulse         = 1'b1;
            end
            stream_data_valid_f2g = 1'b1;
            stream_data_f2g       = word_q[i];
            @(negedge clk);
            strm_f2g_start_pulse = 1'b0;
        end
        stream_data_valid_f2g = 1'b0;
        t = 0;
        while (st_irq_count == base && t < TIMEOUT_CYCLES) begin
            @(negedge clk);
            t++;
        end
        if (st_irq_count == base) begin
            report_abort("store DMA raised no interrupt");
        end
        // Stray word while idle must not reach the sentinel address
        stream_data_valid_f2g = 1'b1;
        stream_data_f2g       = 16'hbad0;
        @(negedge clk);
        stream_data_valid_f2g = 1'b0;
        repeat (IDLE_CYCLES) @(negedge clk);
        if (st_irq_count - base != 1) begin
            report_mismatch("interrupt_pulse[0] count", 32'd1, 32'(st_irq_count - base));
        end
    endtask

    task automatic load_dma_run(input logic [31:0] start, input int nw);
        int base;
        int t;
        int got;
        base = ld_irq_count;
        got  = 0;
        @(negedge clk);
        cfg_ld_dma_header.start_addr = glb_pkg::glb_addr_t'(start);
        cfg_ld_dma_header.num_words  = glb_pkg::num_words_t'(nw);
        strm_g2f_start_pulse         = 1'b1;
        @(negedge clk);
        strm_g2f_start_pulse = 1'b0;
        t = 0;
        // Collect words until the interrupt shows up
        while (ld_irq_count == base && t < TIMEOUT_CYCLES) begin
            if (stream_data_valid_g2f) begin
                if (got >= nw) begin
                    report_problem("load DMA sent more words than its header asks for");
                end else if (stream_data_g2f !== word_q[got]) begin
                    report_mismatch($sformatf("stream_data_g2f word %0d", got),
                                    32'(word_q[got]), 32'(stream_data_g2f));
                end
                got++;
            end
            @(negedge clk);
            t++;
        end
        if (ld_irq_count == base) begin
            report_abort("load DMA raised no interrupt");
        end
        // Stream must stay quiet after the interrupt
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            if (stream_data_valid_g2f) begin
                report_problem("load DMA sent a word after its interrupt");
            end
            @(negedge clk);
        end
        if (got != nw) begin
            report_mismatch("stream word count", 32'(nw), 32'(got));
        end
        if (ld_irq_count - base != 1) begin
            report_mismatch("interrupt_pulse[1] count", 32'd1, 32'(ld_irq_count - base));
        end
    endtask

    task automatic read_words(input int fd, input int count);
        logic [31:0] w;
        int          n;
        word_q.delete();
        for (int i = 0; i < count; i++) begin
            n = $fscanf(fd, "%h", w);
            if (n != 1) begin
                report_abort("input file ends inside a DMA record");
            end
            word_q.push_back(glb_pkg::glb_data_t'(w));
        end
    endtask

    initial begin
        int                 fd;
        int                 n;
        int                 records;
        logic               reading;
        logic [7:0]         op;
        logic [8*128-1:0]   line_buf;
        logic [31:0]        f_a;
        logic [31:0]        f_b;
        clk                   = 1'b0;
        rst_n                 = 1'b0;
        proc_wr_packet        = '0;
        proc_rdrq_packet      = '0;
        stream_data_f2g       = '0;
        stream_data_valid_f2g = 1'b0;
        cfg_st_dma_header     = '0;
        cfg_ld_dma_header     = '0;
        strm_f2g_start_pulse  = 1'b0;
        strm_g2f_start_pulse  = 1'b0;
        records               = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle_outputs();

        fd = $fopen("tests/glb_core_input.txt", "r");
        if (fd == 0) begin
            report_abort("cannot open tests/glb_core_input.txt");
        end
        reading = (fd != 0);
        while (reading && !aborted) begin
            n = $fscanf(fd, "%s", op);
            if (n != 1) begin
                reading = 1'b0;
            end else if (op == "#") begin
                // Comment line
                n = $fgets(line_buf, fd);
            end else begin
                // Every record starts with two hex fields
                n = $fscanf(fd, "%h %h", f_a, f_b);
                records++;
                if (n != 2) begin
                    report_abort($sformatf("malformed record %0d", records));
                end else if (op == "W") begin
                    proc_write(f_a, f_b);
                end else if (op == "R") begin
                    proc_read_check(f_a, f_b);
                end else if ((op == "S" || op == "L") && f_b > MAX_WORDS) begin
                    report_abort($sformatf("record %0d has too many words", records));
                end else if (op == "S") begin
                    read_words(fd, int'(f_b));
                    store_dma_run(f_a, int'(f_b));
                end else if (op == "L") begin
                    read_words(fd, int'(f_b));
                    load_dma_run(f_a, int'(f_b));
                end else begin
                    report_abort($sformatf("unknown opcode in record %0d", records));
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        repeat (IDLE_CYCLES) @(negedge clk);
        $display("Records: %0d, errors: %0d", records, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src/glb_core.sv ====
/* Global buffer tile core without tile chaining or configuration DMA.
   Processor accesses on a path must not overlap a running DMA on that path */
`timescale 1ns/1ps
`include "glb_defines.svh"

module glb_core (
    input  logic                  clk,
    input  logic                  rst_n,

    // Processor
    input  glb_pkg::wr_packet_t   proc_wr_packet,
    input  glb_pkg::rdrq_packet_t proc_rdrq_packet,
    output glb_pkg::rdrs_packet_t proc_rdrs_packet,

    // Fabric stream
    input  glb_pkg::glb_data_t    stream_data_f2g,
    input  logic                  stream_data_valid_f2g,
    output glb_pkg::glb_data_t    stream_data_g2f,
    output logic                  stream_data_valid_g2f,

    // DMA headers
    input  glb_pkg::dma_header_t  cfg_st_dma_header,
    input  glb_pkg::dma_header_t  cfg_ld_dma_header,

    // One start pulse per DMA
    input  logic                  strm_f2g_start_pulse,
    input  logic                  strm_g2f_start_pulse,

    // Bit 0 store done, bit 1 load done
    output logic [1:0]            interrupt_pulse
);

    // DMA to switch
    glb_pkg::wr_packet_t   wr_packet_d2sw;
    glb_pkg::rdrq_packet_t rdrq_packet_d2sw;
    glb_pkg::rdrs_packet_t rdrs_packet_sw2d;

    // Switch to banks and back
    glb_pkg::wr_packet_t   wr_packet_sw2b [`BANKS_PER_TILE];
    glb_pkg::rdrq_packet_t rdrq_packet_sw2b [`BANKS_PER_TILE];
    glb_pkg::rdrs_packet_t rdrs_packet_b2sw [`BANKS_PER_TILE];

    // Raw done pulses
    logic                  st_done_pulse;
    logic                  ld_done_pulse;

    // Banks
    for (genvar i = 0; i < `BANKS_PER_TILE; i++) begin : g_bank
        glb_bank bank (
            .clk         (clk),
            .rst_n       (rst_n),
            .wr_packet   (wr_packet_sw2b[i]),
            .rdrq_packet (rdrq_packet_sw2b[i]),
            .rdrs_packet (rdrs_packet_b2sw[i])
        );
    end

    glb_core_switch glb_core_switch (
        .clk              (clk),
        .rst_n            (rst_n),
        .wr_packet_d2sw   (wr_packet_d2sw),
        .proc_wr_packet   (proc_wr_packet),
        .rdrq_packet_d2sw (rdrq_packet_d2sw),
        .proc_rdrq_packet (proc_rdrq_packet),
        .wr_packet_sw2b   (wr_packet_sw2b),
        .rdrq_packet_sw2b (rdrq_packet_sw2b),
        .rdrs_packet_b2sw (rdrs_packet_b2sw),
        .rdrs_packet_sw2d (rdrs_packet_sw2d),
        .proc_rdrs_packet (proc_rdrs_packet)
    );

    // Fabric to memory
    glb_core_store_dma store_dma (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cfg_st_dma_header     (cfg_st_dma_header),
        .strm_start_pulse      (strm_f2g_start_pulse),
        .stream_data_f2g       (stream_data_f2g),
        .stream_data_valid_f2g (stream_data_valid_f2g),
        .wr_packet             (wr_packet_d2sw),
        .done_pulse            (st_done_pulse)
    );

    // Memory to fabric
    glb_core_load_dma load_dma (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cfg_ld_dma_header     (cfg_ld_dma_header),
        .strm_start_pulse      (strm_g2f_start_pulse),
        .rdrq_packet           (rdrq_packet_d2sw),
        .rdrs_packet           (rdrs_packet_sw2d),
        .stream_data_g2f       (stream_data_g2f),
        .stream_data_valid_g2f (stream_data_valid_g2f),
        .done_pulse            (ld_done_pulse)
    );

    // Interrupts lag done by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            interrupt_pulse <= 2'b00;
        end else begin
            interrupt_pulse <= {ld_done_pulse, st_done_pulse};
        end
    end

endmodule

// ==== src/glb_core_load_dma.sv ====
/* Memory-to-stream DMA with one header. Issues one read per cycle with no
   stall; the stream cannot apply back-pressure */
`timescale 1ns/1ps

module glb_core_load_dma (
    input  logic                  clk,
    input  logic                  rst_n,
    input  glb_pkg::dma_header_t  cfg_ld_dma_header,
    input  logic                  strm_start_pulse,
    output glb_pkg::rdrq_packet_t rdrq_packet,
    input  glb_pkg::rdrs_packet_t rdrs_packet,
    output glb_pkg::glb_data_t    stream_data_g2f,
    output logic                  stream_data_valid_g2f,
    output logic                  done_pulse
);

    glb_pkg::dma_state_t state;

    // Request side
    glb_pkg::glb_addr_t  rq_addr;
    glb_pkg::num_words_t rq_left;
    logic                rq_fire;

    // Response side
    glb_pkg::num_words_t rs_left;
    logic                rs_take;

    // Stream output registers
    logic                strm_valid_q;
    glb_pkg::glb_data_t  strm_data_q;
    logic                done_q;

    assign rq_fire = (state == glb_pkg::DMA_BUSY) && (rq_left != '0);
    assign rs_take = (state == glb_pkg::DMA_BUSY) && (rs_left != '0) && rdrs_packet.rd_data_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= glb_pkg::DMA_IDLE;
            rq_addr      <= '0;
            rq_left      <= '0;
            rs_left      <= '0;
            strm_valid_q <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            strm_valid_q <= rs_take;
            done_q       <= 1'b0;
            case (state)
                glb_pkg::DMA_IDLE: begin
                    if (strm_start_pulse) begin
                        state   <= glb_pkg::DMA_BUSY;
                        rq_addr <= cfg_ld_dma_header.start_addr;
                        rq_left <= cfg_ld_dma_header.num_words;
                        rs_left <= cfg_ld_dma_header.num_words;
                    end
                end
                glb_pkg::DMA_BUSY: begin
                    // Requests and responses overlap
                    if (rq_fire) begin
                        rq_addr <= rq_addr + glb_pkg::glb_addr_t'(1);
                        rq_left <= rq_left - glb_pkg::num_words_t'(1);
                    end
                    if (rs_take) begin
                        rs_left <= rs_left - glb_pkg::num_words_t'(1);
                    end
                    // Last word already on the stream
                    if (rs_left == '0) begin
                        done_q <= 1'b1;
                        state  <= glb_pkg::DMA_IDLE;
                    end
                end
                default: state <= glb_pkg::DMA_IDLE;
            endcase
        end
    end

    // Stream word, registered from the response
    always_ff @(posedge clk) begin
        if (rs_take) begin
            strm_data_q <= rdrs_packet.rd_data;
        end
    end

    assign rdrq_packet.rd_en      = rq_fire;
    assign rdrq_packet.rd_addr    = rq_addr;
    assign stream_data_g2f        = strm_data_q;
    assign stream_data_valid_g2f  = strm_valid_q;
    assign done_pulse             = done_q;

endmodule

// ==== src/glb_core_store_dma.sv ====
/* Stream-to-memory DMA with one header. Words arriving while idle are lost and
   a start pulse while busy is ignored; addresses wrap at the tile size */
`timescale 1ns/1ps

module glb_core_store_dma (
    input  logic                 clk,
    input  logic                 rst_n,
    input  glb_pkg::dma_header_t cfg_st_dma_header,
    input  logic                 strm_start_pulse,
    input  glb_pkg::glb_data_t   stream_data_f2g,
    input  logic                 stream_data_valid_f2g,
    output glb_pkg::wr_packet_t  wr_packet,
    output logic                 done_pulse
);

    glb_pkg::dma_state_t state;

    // Next write address and words still expected
    glb_pkg::glb_addr_t  cur_addr;
    glb_pkg::num_words_t remaining;

    // Registered write packet
    logic                wr_en_q;
    glb_pkg::glb_addr_t  wr_addr_q;
    glb_pkg::glb_data_t  wr_data_q;
    logic                done_q;

    // Word accepted this cycle
    logic                accept;

    assign accept = (state == glb_pkg::DMA_BUSY) && (remaining != '0) && stream_data_valid_f2g;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= glb_pkg::DMA_IDLE;
            cur_addr  <= '0;
            remaining <= '0;
            wr_en_q   <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            wr_en_q <= accept;
            done_q  <= 1'b0;
            case (state)
                glb_pkg::DMA_IDLE: begin
                    if (strm_start_pulse) begin
                        state     <= glb_pkg::DMA_BUSY;
                        cur_addr  <= cfg_st_dma_header.start_addr;
                        remaining <= cfg_st_dma_header.num_words;
                    end
                end
                glb_pkg::DMA_BUSY: begin
                    // Empty job finishes at once
                    if (remaining == '0) begin
                        done_q <= 1'b1;
                        state  <= glb_pkg::DMA_IDLE;
                    end else if (stream_data_valid_f2g) begin
                        cur_addr  <= cur_addr + glb_pkg::glb_addr_t'(1);
                        remaining <= remaining - glb_pkg::num_words_t'(1);
                        // Last word goes out together with done
                        if (remaining == glb_pkg::num_words_t'(1)) begin
                            done_q <= 1'b1;
                            state  <= glb_pkg::DMA_IDLE;
                        end
                    end
                end
                default: state <= glb_pkg::DMA_IDLE;
            endcase
        end
    end

    // Payload follows the accepted word
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr_q <= cur_addr;
            wr_data_q <= stream_data_f2g;
        end
    end

    assign wr_packet.wr_en   = wr_en_q;
    assign wr_packet.wr_addr = wr_addr_q;
    assign wr_packet.wr_data = wr_data_q;
    assign done_pulse        = done_q;

endmodule

// ==== src/glb_core_switch.sv ====
/* Packet switch between two requesters and the banks. DMA beats processor on
   the same path in the same cycle; the losing request is dropped, not held */
`timescale 1ns/1ps
`include "glb_defines.svh"

module glb_core_switch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  glb_pkg::wr_packet_t   wr_packet_d2sw,
    input  glb_pkg::wr_packet_t   proc_wr_packet,
    input  glb_pkg::rdrq_packet_t rdrq_packet_d2sw,
    input  glb_pkg::rdrq_packet_t proc_rdrq_packet,
    output glb_pkg::wr_packet_t   wr_packet_sw2b [`BANKS_PER_TILE],
    output glb_pkg::rdrq_packet_t rdrq_packet_sw2b [`BANKS_PER_TILE],
    input  glb_pkg::rdrs_packet_t rdrs_packet_b2sw [`BANKS_PER_TILE],
    output glb_pkg::rdrs_packet_t rdrs_packet_sw2d,
    output glb_pkg::rdrs_packet_t proc_rdrs_packet
);

    localparam int BANK_SEL_WIDTH = `GLB_ADDR_WIDTH - `BANK_ADDR_WIDTH;

    // Arbitration winners
    glb_pkg::wr_packet_t       wr_win;
    glb_pkg::rdrq_packet_t     rdrq_win;

    // Registered write request
    logic                      wr_en_q;
    glb_pkg::glb_addr_t        wr_addr_q;
    glb_pkg::glb_data_t        wr_data_q;
    logic [BANK_SEL_WIDTH-1:0] wr_bank_sel;

    // Registered read request, first tag stage rides along
    logic                      rd_en_q;
    glb_pkg::glb_addr_t        rd_addr_q;
    logic                      rd_src_dma_q;
    logic [BANK_SEL_WIDTH-1:0] rd_bank_sel;

    // Second tag stage, aligned with bank output
    logic                      tag_src_dma_q2;
    logic [BANK_SEL_WIDTH-1:0] tag_bank_q2;

    // Registered response
    logic                      rs_valid_dma_q;
    logic                      rs_valid_proc_q;
    glb_pkg::glb_data_t        rs_data_q;

    // DMA first on both paths
    assign wr_win   = wr_packet_d2sw.wr_en ? wr_packet_d2sw : proc_wr_packet;
    assign rdrq_win = rdrq_packet_d2sw.rd_en ? rdrq_packet_d2sw : proc_rdrq_packet;

    // Top address bits name the bank
    assign wr_bank_sel = wr_addr_q[`GLB_ADDR_WIDTH-1:`BANK_ADDR_WIDTH];
    assign rd_bank_sel = rd_addr_q[`GLB_ADDR_WIDTH-1:`BANK_ADDR_WIDTH];

    // Control and tags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_q         <= 1'b0;
            rd_en_q         <= 1'b0;
            rd_src_dma_q    <= 1'b0;
            tag_src_dma_q2  <= 1'b0;
            tag_bank_q2     <= '0;
            rs_valid_dma_q  <= 1'b0;
            rs_valid_proc_q <= 1'b0;
        end else begin
            wr_en_q         <= wr_win.wr_en;
            rd_en_q         <= rdrq_win.rd_en;
            rd_src_dma_q    <= rdrq_packet_d2sw.rd_en;
            tag_src_dma_q2  <= rd_src_dma_q;
            tag_bank_q2     <= rd_bank_sel;
            // Steer the bank strobe to exactly one requester
            rs_valid_dma_q  <= rdrs_packet_b2sw[tag_bank_q2].rd_data_valid && tag_src_dma_q2;
            rs_valid_proc_q <= rdrs_packet_b2sw[tag_bank_q2].rd_data_valid && !tag_src_dma_q2;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        wr_addr_q <= wr_win.wr_addr;
        wr_data_q <= wr_win.wr_data;
        rd_addr_q <= rdrq_win.rd_addr;
        rs_data_q <= rdrs_packet_b2sw[tag_bank_q2].rd_data;
    end

    // Fan out to banks, only the selected one enabled
    always_comb begin
        for (int b = 0; b < `BANKS_PER_TILE; b++) begin
            wr_packet_sw2b[b].wr_en     = wr_en_q && (wr_bank_sel == BANK_SEL_WIDTH'(b));
            wr_packet_sw2b[b].wr_addr   = wr_addr_q;
            wr_packet_sw2b[b].wr_data   = wr_data_q;
            rdrq_packet_sw2b[b].rd_en   = rd_en_q && (rd_bank_sel == BANK_SEL_WIDTH'(b));
            rdrq_packet_sw2b[b].rd_addr = rd_addr_q;
        end
    end

    // Data shared, strobes separate
    assign rdrs_packet_sw2d.rd_data_valid = rs_valid_dma_q;
    assign rdrs_packet_sw2d.rd_data       = rs_data_q;
    assign proc_rdrs_packet.rd_data_valid = rs_valid_proc_q;
    assign proc_rdrs_packet.rd_data       = rs_data_q;

endmodule

// ==== src/glb_bank.sv ====
/* Single-port-per-direction SRAM bank. Only the low address bits are used;
   a read colliding with a write to the same word returns the old word */
`timescale 1ns/1ps
`include "glb_defines.svh"

module glb_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  glb_pkg::wr_packet_t   wr_packet,
    input  glb_pkg::rdrq_packet_t rdrq_packet,
    output glb_pkg::rdrs_packet_t rdrs_packet
);

    // Storage
    glb_pkg::glb_data_t  mem [2**`BANK_ADDR_WIDTH];

    // Addresses inside this bank
    glb_pkg::bank_addr_t wr_bank_addr;
    glb_pkg::bank_addr_t rd_bank_addr;

    // Registered read port
    logic                rd_valid_q;
    glb_pkg::glb_data_t  rd_data_q;

    // Drop the bank select bits
    assign wr_bank_addr = wr_packet.wr_addr[`BANK_ADDR_WIDTH-1:0];
    assign rd_bank_addr = rdrq_packet.rd_addr[`BANK_ADDR_WIDTH-1:0];

    // Write and read in one process, so a same-address read sees the old word
    always_ff @(posedge clk) begin
        if (wr_packet.wr_en) begin
            mem[wr_bank_addr] <= wr_packet.wr_data;
        end
        if (rdrq_packet.rd_en) begin
            rd_data_q <= mem[rd_bank_addr];
        end
    end

    // Response strobe, one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rdrq_packet.rd_en;
        end
    end

    assign rdrs_packet.rd_data_valid = rd_valid_q;
    assign rdrs_packet.rd_data       = rd_data_q;

endmodule

// ==== src/glb_pkg.sv ====
/* Shared types of the global buffer tile. Widths come from the defines header */
`include "glb_defines.svh"

package glb_pkg;

    // Meaningful widths
    typedef logic [`GLB_DATA_WIDTH-1:0]  glb_data_t;
    typedef logic [`GLB_ADDR_WIDTH-1:0]  glb_addr_t;
    typedef logic [`BANK_ADDR_WIDTH-1:0] bank_addr_t;
    // One extra bit so a full tile fits
    typedef logic [`GLB_ADDR_WIDTH:0]    num_words_t;

    // Write request
    typedef struct packed {
        logic      wr_en;
        glb_addr_t wr_addr;
        glb_data_t wr_data;
    } wr_packet_t;

    // Read request
    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    // Read response
    typedef struct packed {
        logic      rd_data_valid;
        glb_data_t rd_data;
    } rdrs_packet_t;

    // One DMA job
    typedef struct packed {
        glb_addr_t  start_addr;
        num_words_t num_words;
    } dma_header_t;

    // Shared by store and load DMA
    typedef enum logic {
        DMA_IDLE,
        DMA_BUSY
    } dma_state_t;

endpackage

// ==== src/glb_defines.svh ====
/* Tile geometry of the global buffer. The bank count must stay a power of two,
   with the bank chosen by the address bits above BANK_ADDR_WIDTH */
`ifndef GLB_DEFINES_SVH
`define GLB_DEFINES_SVH

// Word width of banks and stream
`define GLB_DATA_WIDTH 16

// Word address across the whole tile
`define GLB_ADDR_WIDTH 10

// Word address inside one bank
`define BANK_ADDR_WIDTH 9

// Banks in one tile, 2^(GLB_ADDR_WIDTH-BANK_ADDR_WIDTH)
`define BANKS_PER_TILE 2

`endif
